// ==== Makefile ====
# Verilator build and run of the sandbox testbench

TOP := sandboxTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and scan sim.log for the fail message"
	@echo "  clean  remove the Verilator output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f build.f -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -qF "*** TEST PASSED ***" sim.log || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// ==== bench/sandboxTb.sv ====
/* table-driven host model for sandboxTop with StoreDepth 16; rows build on earlier writes
   the last two rows are spaced out to count one LED blink each */
`timescale 1ns/1ps

module sandboxTb;
  import hostLinkPkg::*;

  localparam int StoreDepth  = 16;
  localparam int ClockPeriod = 20;             // ns
  localparam int SlowPeriod  = 16 * ClockPeriod;
  localparam int NumRows     = 21;
  localparam int BlinkRows   = 2;               // last rows spaced out for the LED
  localparam int BlinkSettle = 40;              // cycles to outlast one full blink
  localparam int WatchdogNs  = NumRows * 40 * ClockPeriod + 4 * SlowPeriod;

  typedef struct {
    string     name;
    control_t  control;
    dataWord_t data;
    status_t   expStatus;
    dataWord_t expOutput;
  } testRow_t;

  // --------------------
  // data word fields selector | tag | value | index
  testRow_t rows [NumRows] = '{
    '{"resetMax",   8'h00, 32'h0300_0000, 8'h00, 32'h0000_0000},  // nothing written yet
    '{"writeV5",    8'h01, 32'h0000_4005, 8'h01, 32'h0000_0000},
    '{"writeV2",    8'hf1, 32'h0000_4002, 8'h01, 32'h0000_0000},  // upper control bits ignored
    '{"writeV9",    8'h01, 32'h0000_7a09, 8'h01, 32'h0000_0000},
    '{"writeT5",    8'h03, 32'h0033_0005, 8'h01, 32'h0000_0000},
    '{"writeT9",    8'h03, 32'h0033_0009, 8'h01, 32'h0000_0000},
    '{"writeT7",    8'h03, 32'h0033_0007, 8'h01, 32'h0000_0000},  // tag write alone marks entry
    '{"writeOor",   8'h01, 32'h0000_ff14, 8'h01, 32'h0000_0000},  // index 20 dropped but acked
    '{"readV5",     8'h00, 32'h0000_0005, 8'h01, 32'h4000_0000},  // tag write left value alone
    '{"readV3",     8'h02, 32'h0000_0003, 8'h00, 32'h0000_0000},  // unwritten
    '{"readOor",    8'h00, 32'h0000_0014, 8'h00, 32'h0000_0000},
    '{"findV40",    8'h00, 32'h0100_4000, 8'h01, 32'h0200_0000},  // lowest of entries 2 and 5
    '{"findNone",   8'hfc, 32'h0100_ff00, 8'h00, 32'h0000_0000},  // ff only went out of range
    '{"countT33",   8'h00, 32'h0233_0000, 8'h01, 32'h0300_0000},  // entries 5, 7 and 9
    '{"countT00",   8'h00, 32'h0200_0000, 8'h01, 32'h0100_0000},  // entry 2 only
    '{"maxV",       8'h00, 32'h0300_0000, 8'h01, 32'h7a00_0000},
    '{"overwrite9", 8'h01, 32'h0000_1009, 8'h01, 32'h0000_0000},
    '{"maxAfter",   8'h00, 32'h0300_0000, 8'h01, 32'h4000_0000},
    '{"badSel",     8'h00, 32'h0700_0005, 8'h02, 32'h0000_0000},
    '{"blinkRead",  8'h00, 32'h0000_0002, 8'h01, 32'h4000_0000},
    '{"blinkWrite", 8'h01, 32'h0000_1103, 8'h01, 32'h0000_0000}
  };

  logic      masterClock = 1'b0;
  logic      slowClock   = 1'b0;
  logic      reset;
  logic      dataReceived;
  control_t  control;
  dataWord_t inputData;
  logic      clearDR;
  logic      transmitData;
  status_t   status;
  dataWord_t outputData;
  logic      rxIndicator;

  logic [31:0] lfsrState   = 32'ha2d7_cbb9;
  realtime     lastSlowFall = 0;
  int          pulseCount   = 0;

  sandboxTop #(.StoreDepth(StoreDepth)) i_sandboxTop (
    .masterClock  (masterClock),
    .slowClock    (slowClock),
    .reset        (reset),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData),
    .clearDR      (clearDR),
    .transmitData (transmitData),
    .status       (status),
    .outputData   (outputData),
    .rxIndicator  (rxIndicator)
  );

  always #(ClockPeriod / 2) masterClock = ~masterClock;
  always #(SlowPeriod / 2) slowClock = ~slowClock;  // 8 master cycles per half

  // --------------------
  // failure reporting and compares
  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic checkStatus(input string name, input status_t exp, input status_t act);
    if (act !== exp)
      stopOnError($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic checkOutput(input string name, input dataWord_t exp, input dataWord_t act);
    if (act !== exp)
      stopOnError($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic checkLevel(input string name, input logic exp, input logic act);
    if (act !== exp)
      stopOnError($sformatf("ERR %s expected %b actual %b", name, exp, act));
  endtask

  task automatic checkCount(input string name, input int exp, input int act);
    if (act != exp)
      stopOnError($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
  endtask

  // --------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawBits(input int count, output int bits);
    bits = 0;
    for (int i = 0; i < count; i++)
    begin
      lfsrState = nextLfsr(lfsrState);  // one step per bit
      bits = (bits << 1) | int'(lfsrState[0]);
    end
  endtask

  // --------------------
  // one host request, answer and release
  task automatic applyRow(input testRow_t row);
    int gap;
    int hold;
    int cycles;
    drawBits(3, gap);
    repeat (gap) @(posedge masterClock);
    @(posedge masterClock);
    #2;
    control      = row.control;
    inputData    = row.data;
    dataReceived = 1'b1;
    @(posedge masterClock);   // edge 0 samples the request
    cycles = 0;
    @(negedge masterClock);
    while (!transmitData)
    begin
      @(negedge masterClock);
      cycles++;
    end
    checkCount({row.name, "/txDelay"}, 3, cycles);
    checkStatus({row.name, "/status"}, row.expStatus, status);
    checkOutput({row.name, "/output"}, row.expOutput, outputData);
    cycles = 0;
    while (!clearDR)
    begin
      @(negedge masterClock);
      cycles++;
      checkLevel({row.name, "/txHeld"}, 1'b1, transmitData);
    end
    checkCount({row.name, "/clearDelay"}, 2, cycles);
    drawBits(2, hold);
    repeat (hold)             // host back-pressure
    begin
      @(negedge masterClock);
      checkLevel({row.name, "/txWait"}, 1'b1, transmitData);
      checkLevel({row.name, "/clearWait"}, 1'b1, clearDR);
    end
    @(posedge masterClock);
    #2;
    dataReceived = 1'b0;
    @(negedge masterClock);   // drop not seen yet
    checkLevel({row.name, "/txBeforeEdge"}, 1'b1, transmitData);
    @(negedge masterClock);
    checkLevel({row.name, "/txFall"}, 1'b0, transmitData);
    checkLevel({row.name, "/clearFall"}, 1'b0, clearDR);
  endtask

  // --------------------
  // LED monitors
  always @(negedge slowClock)
    lastSlowFall = $realtime;

  always @(rxIndicator)
    if (reset === 1'b1 && ($realtime - lastSlowFall) > 4 * ClockPeriod)
      stopOnError("rxIndicator changed away from a slowClock falling edge");

  always @(posedge rxIndicator)
    if (reset === 1'b1)
      pulseCount++;

  initial
  begin
    #(WatchdogNs);
    stopOnError("watchdog expired, the request handshake never completed");
  end

  // --------------------
  // main sequence
  initial
  begin
    int startPulses;
    reset        = 1'b0;
    dataReceived = 1'b0;
    control      = '0;
    inputData    = '0;
    repeat (4) @(posedge masterClock);
    #2;
    reset = 1'b1;
    @(negedge masterClock);
    checkLevel("reset/transmitData", 1'b0, transmitData);
    checkLevel("reset/clearDR", 1'b0, clearDR);
    checkLevel("reset/rxIndicator", 1'b0, rxIndicator);
    checkStatus("reset/status", 8'h00, status);
    checkOutput("reset/output", 32'h0, outputData);
    for (int i = 0; i < NumRows; i++)
    begin
      if (i >= NumRows - BlinkRows)
      begin
        repeat (BlinkSettle) @(negedge masterClock);  // earlier blink over
        checkLevel({rows[i].name, "/ledIdle"}, 1'b0, rxIndicator);
        startPulses = pulseCount;
        applyRow(rows[i]);
        repeat (BlinkSettle) @(negedge masterClock);
        checkCount({rows[i].name, "/ledPulses"}, startPulses + 1, pulseCount);
        checkLevel({rows[i].name, "/ledDone"}, 1'b0, rxIndicator);
      end
      else
        applyRow(rows[i]);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== build.f ====
hw/esfaPkg.sv
hw/hostLinkPkg.sv
hw/sandboxProcess.sv
hw/elementStore.sv
hw/queryEngine.sv
hw/activityIndicator.sv
hw/sandboxTop.sv
bench/sandboxTb.sv

// ==== hw/activityIndicator.sv ====
/* one blink of one slowClock period per request; requests during a blink are not queued
   slowClock edges are seen a few masterClock cycles late through the synchronizer */
`timescale 1ns/1ps

module activityIndicator (
  input  logic masterClock,
  input  logic reset,        // sync, active low
  input  logic slowClock,    // LED time base, unrelated to masterClock
  input  logic accepted,     // one pulse per request
  output logic rxIndicator   // LED drive
);
  typedef enum logic [1:0] {
    idle,     // LED off, waiting for a request
    armed,    // waiting for a slow falling edge
    lit,      // LED on, low half of the slow period
    dimming   // LED on, waiting for the closing falling edge
  } blinkState_t;

  blinkState_t state;
  logic        slowMeta;  // first sync stage
  logic        slowSync;
  logic        slowLast;  // previous synced level
  logic        slowFall;

  assign slowFall = slowLast && !slowSync;

  // --------------------
  // slow clock sampling
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      slowMeta <= 1'b0;
      slowSync <= 1'b0;
      slowLast <= 1'b0;
    end
    else
    begin
      slowMeta <= slowClock;
      slowSync <= slowMeta;
      slowLast <= slowSync;
    end
  end

  // --------------------
  // blink FSM
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      state       <= idle;
      rxIndicator <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
          if (accepted)
            state <= armed;
        armed:
          if (slowFall)  // fall after a high level
          begin
            rxIndicator <= 1'b1;
            state       <= lit;
          end
        lit:
          if (slowSync)
            state <= dimming;
        dimming:
          if (slowFall)
          begin
            rxIndicator <= 1'b0;
            state       <= idle;
          end
        default:
          state <= idle;
      endcase
    end
  end

endmodule

// ==== hw/elementStore.sv ====
/* one write per cycle; writes to an index at or beyond StoreDepth are dropped
   StoreDepth from 1 to 256 */
`timescale 1ns/1ps

module elementStore #(
  parameter int StoreDepth = 64
) (
  input  logic                             masterClock,
  input  logic                             reset,         // sync, active low
  input  esfaPkg::storeWrite_t             storeWrite,
  output esfaPkg::value_t [StoreDepth-1:0] entryValues,   // per-entry value
  output esfaPkg::tag_t   [StoreDepth-1:0] entryTags,     // per-entry metadata tag
  output logic            [StoreDepth-1:0] entryWritten   // entry holds data
);
  import esfaPkg::*;

  logic [StoreDepth-1:0] slotSelect;  // one-hot, empty when out of range

  // --------------------
  // index decode
  always_comb
  begin
    slotSelect = '0;
    for (int i = 0; i < StoreDepth; i++)
    begin
      if (storeWrite.writeEnable && storeWrite.index == index_t'(i))
        slotSelect[i] = 1'b1;
    end
  end

  // --------------------
  // entry registers
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      entryValues  <= '0;
      entryTags    <= '0;
      entryWritten <= '0;   // every entry unwritten
    end
    else
    begin
      for (int i = 0; i < StoreDepth; i++)
      begin
        if (slotSelect[i])
        begin
          if (storeWrite.writeTag)
            entryTags[i] <= storeWrite.data;    // metadata write
          else
            entryValues[i] <= storeWrite.data;  // value write
          entryWritten[i] <= 1'b1;  // either kind marks the entry
        end
      end
    end
  end

endmodule

// ==== hw/esfaPkg.sv ====
/* element store types shared by the request FSM, the store and the query engine
   selector codes other than the four listed here are answered as bad requests */
package esfaPkg;

  // --------------------
  // field types of one entry
  typedef logic [7:0] index_t;  // entry index, data bits 7..0
  typedef logic [7:0] value_t;  // element value, data bits 15..8
  typedef logic [7:0] tag_t;    // metadata tag, data bits 23..16

  // query kind, data bits 31..24
  typedef enum logic [7:0] {
    selReadValue = 8'd0,  // value at index
    selFindValue = 8'd1,  // lowest index holding value
    selCountTag  = 8'd2,  // entries carrying tag
    selMaxValue  = 8'd3   // largest stored value
  } selector_t;

  // --------------------
  // one store write, single-cycle enable
  typedef struct packed {
    logic   writeEnable;
    logic   writeTag;     // tag write instead of value write
    index_t index;
    value_t data;         // value or tag, same width
  } storeWrite_t;

  // one query, single-cycle strobe
  typedef struct packed {
    logic      strobe;
    selector_t selector;
    index_t    index;
    value_t    value;
    tag_t      tag;
  } queryRequest_t;

  typedef struct packed {
    logic   found;
    value_t value;        // value, index or count depending on selector
    logic   badSelector;
  } queryResult_t;

endpackage

// ==== hw/hostLinkPkg.sv ====
/* host link frame types; control bits above 1 are ignored and status bits above 1 stay zero
   the decoded command pulls its field types from esfaPkg, so that package compiles first */
package hostLinkPkg;

  // --------------------
  // raw frame words
  typedef logic [7:0]  control_t;   // control byte from the host
  typedef logic [31:0] dataWord_t;  // data word in both directions
  typedef logic [7:0]  status_t;    // status byte back to the host

  // control byte bits
  localparam int CtrlUpdateBit   = 0;  // set for an update
  localparam int CtrlMetadataBit = 1;  // update targets the tag

  // status byte bits
  localparam int StatusFlagBit = 0;  // found flag or update ack
  localparam int StatusBadBit  = 1;  // unknown selector

  // --------------------
  // one decoded host request
  typedef struct packed {
    logic                isUpdate;
    logic                isMetadata;
    esfaPkg::index_t     index;
    esfaPkg::value_t     value;
    esfaPkg::tag_t       metadata;
    esfaPkg::selector_t  selector;   // raw code, may be unknown
  } hostCommand_t;

  // answer word layout
  localparam int OutputValueLsb = 24;  // result byte sits on top

endpackage

// ==== hw/queryEngine.sv ====
/* one query per strobe, answered one cycle later; only written entries take part
   selCountTag saturates at 255 */
`timescale 1ns/1ps

module queryEngine #(
  parameter int StoreDepth = 64
) (
  input  logic                             masterClock,
  input  logic                             reset,        // sync, active low
  input  esfaPkg::queryRequest_t           query,
  input  esfaPkg::value_t [StoreDepth-1:0] entryValues,
  input  esfaPkg::tag_t   [StoreDepth-1:0] entryTags,
  input  logic            [StoreDepth-1:0] entryWritten,
  output esfaPkg::queryResult_t            result,
  output logic                             resultValid   // one cycle after strobe
);
  import esfaPkg::*;

  localparam int CountMax = 255;  // largest count the value byte holds

  logic         readFound;
  value_t       readValue;
  logic         hitFound;
  index_t       hitIndex;
  logic [8:0]   tagCount;   // room for 256 matches
  value_t       maxValue;
  logic         anyWritten;
  queryResult_t answer;

  // --------------------
  // sweep over all entries
  always_comb
  begin
    readFound  = 1'b0;
    readValue  = '0;
    hitFound   = 1'b0;
    hitIndex   = '0;
    tagCount   = '0;
    maxValue   = '0;
    anyWritten = 1'b0;
    for (int i = StoreDepth - 1; i >= 0; i--)  // downward so the lowest hit wins
    begin
      if (entryWritten[i])
      begin
        if (index_t'(i) == query.index)  // never true for out-of-range index
        begin
          readFound = 1'b1;
          readValue = entryValues[i];
        end
        if (entryValues[i] == query.value)
        begin
          hitFound = 1'b1;
          hitIndex = index_t'(i);
        end
        if (entryTags[i] == query.tag)
          tagCount = tagCount + 9'd1;
        if (entryValues[i] > maxValue)
          maxValue = entryValues[i];
        anyWritten = 1'b1;
      end
    end
  end

  // --------------------
  // selector mux
  always_comb
  begin
    answer = '0;
    case (query.selector)
      selReadValue:
      begin
        answer.found = readFound;
        answer.value = readValue;
      end
      selFindValue:
      begin
        answer.found = hitFound;
        answer.value = hitIndex;    // index reported in the value byte
      end
      selCountTag:
      begin
        answer.found = (tagCount != '0);
        answer.value = (tagCount > CountMax) ? value_t'(CountMax) : tagCount[7:0];
      end
      selMaxValue:
      begin
        answer.found = anyWritten;
        answer.value = maxValue;
      end
      default:
        answer.badSelector = 1'b1;  // found and value stay 0
    endcase
  end

  // --------------------
  // result register
  always_ff @(posedge masterClock)
  begin
    if (!reset)
      resultValid <= 1'b0;
    else
      resultValid <= query.strobe;
  end

  always_ff @(posedge masterClock)
  begin
    if (query.strobe)
      result <= answer;  // held until the next query
  end

endmodule

// ==== hw/sandboxProcess.sv ====
/* one request in flight; the host holds control and inputData while dataReceived is high
   transmitData rises 3 cycles and clearDR 5 cycles after the request is sampled */
`timescale 1ns/1ps

module sandboxProcess (
  input  logic                   masterClock,
  input  logic                   reset,         // sync, active low
  input  logic                   dataReceived,  // request level from the host link
  input  hostLinkPkg::control_t  control,
  input  hostLinkPkg::dataWord_t inputData,
  input  esfaPkg::queryResult_t  result,        // from queryEngine
  input  logic                   resultValid,
  output esfaPkg::storeWrite_t   storeWrite,    // to elementStore
  output esfaPkg::queryRequest_t query,         // to queryEngine
  output logic                   accepted,      // one pulse per request
  output hostLinkPkg::status_t   status,
  output hostLinkPkg::dataWord_t outputData,
  output logic                   transmitData,
  output logic                   clearDR
);
  import hostLinkPkg::*;
  import esfaPkg::*;

  typedef enum logic [2:0] {
    idle,         // waiting for dataReceived
    issue,        // write or query strobe out
    respond,      // store updated or result registered
    announce,     // answer stable
    settle,
    done,
    waitRelease   // host still holds dataReceived
  } procState_t;

  procState_t   state;
  hostCommand_t request;  // decoded straight off the link
  hostCommand_t command;  // latched at acceptance

  // --------------------
  // request decode
  always_comb
  begin
    request.isUpdate   = control[CtrlUpdateBit];
    request.isMetadata = control[CtrlMetadataBit];
    request.index      = inputData[7:0];
    request.value      = inputData[15:8];
    request.metadata   = inputData[23:16];
    request.selector   = selector_t'(inputData[31:24]);  // unknown codes pass through
  end

  // latch on acceptance, payload only
  always_ff @(posedge masterClock)
  begin
    if (state == idle && dataReceived)
      command <= request;
  end

  // --------------------
  // command issue, live for the single issue cycle
  always_comb
  begin
    storeWrite.writeEnable = (state == issue) && command.isUpdate;
    storeWrite.writeTag    = command.isMetadata;
    storeWrite.index       = command.index;
    storeWrite.data        = command.isMetadata ? command.metadata : command.value;

    query.strobe   = (state == issue) && !command.isUpdate;
    query.selector = command.selector;
    query.index    = command.index;
    query.value    = command.value;
    query.tag      = command.metadata;
  end

  assign accepted = (state == issue);  // drives the LED blink

  // --------------------
  // request FSM and host answer
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      state        <= idle;
      status       <= '0;
      outputData   <= '0;
      transmitData <= 1'b0;
      clearDR      <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
          if (dataReceived)
            state <= issue;   // edge 0
        issue:
          state <= respond;   // store or engine acts on edge 1
        respond:
          if (command.isUpdate || resultValid)
          begin
            status     <= '0;
            outputData <= '0;
            if (command.isUpdate)
              status[StatusFlagBit] <= 1'b1;  // plain ack
            else
            begin
              status[StatusFlagBit] <= result.found;
              status[StatusBadBit]  <= result.badSelector;
              outputData[OutputValueLsb +: 8] <= result.value;
            end
            state <= announce;  // answer set on edge 2
          end
        announce:
        begin
          transmitData <= 1'b1;  // edge 3
          state        <= settle;
        end
        settle:
          state <= done;
        done:
        begin
          clearDR <= 1'b1;       // edge 5
          state   <= waitRelease;
        end
        waitRelease:
          if (!dataReceived)     // host let go
          begin
            transmitData <= 1'b0;
            clearDR      <= 1'b0;
            state        <= idle;
          end
        default:
          state <= idle;
      endcase
    end
  end

endmodule

// ==== hw/sandboxTop.sv ====
/* host-facing top; adds no latency over the blocks below
   StoreDepth from 1 to 256 */
`timescale 1ns/1ps

module sandboxTop #(
  parameter int StoreDepth = 64
) (
  input  logic                   masterClock,
  input  logic                   slowClock,     // LED timing only
  input  logic                   reset,         // sync, active low
  input  logic                   dataReceived,
  input  hostLinkPkg::control_t  control,
  input  hostLinkPkg::dataWord_t inputData,
  output logic                   clearDR,
  output logic                   transmitData,
  output hostLinkPkg::status_t   status,
  output hostLinkPkg::dataWord_t outputData,
  output logic                   rxIndicator
);
  import esfaPkg::*;

  // --------------------
  // internal wiring
  storeWrite_t             storeWrite;
  queryRequest_t           query;
  queryResult_t            result;
  logic                    resultValid;
  value_t [StoreDepth-1:0] entryValues;
  tag_t   [StoreDepth-1:0] entryTags;
  logic   [StoreDepth-1:0] entryWritten;
  logic                    accepted;

  sandboxProcess i_sandboxProcess (
    .masterClock  (masterClock),
    .reset        (reset),
    .dataReceived (dataReceived),
    .control      (control),
    .inputData    (inputData),
    .result       (result),
    .resultValid  (resultValid),
    .storeWrite   (storeWrite),
    .query        (query),
    .accepted     (accepted),
    .status       (status),
    .outputData   (outputData),
    .transmitData (transmitData),
    .clearDR      (clearDR)
  );

  elementStore #(.StoreDepth(StoreDepth)) i_elementStore (
    .masterClock  (masterClock),
    .reset        (reset),
    .storeWrite   (storeWrite),
    .entryValues  (entryValues),
    .entryTags    (entryTags),
    .entryWritten (entryWritten)
  );

  queryEngine #(.StoreDepth(StoreDepth)) i_queryEngine (
    .masterClock  (masterClock),
    .reset        (reset),
    .query        (query),
    .entryValues  (entryValues),
    .entryTags    (entryTags),
    .entryWritten (entryWritten),
    .result       (result),
    .resultValid  (resultValid)
  );

  activityIndicator i_activityIndicator (
    .masterClock (masterClock),
    .reset       (reset),
    .slowClock   (slowClock),
    .accepted    (accepted),
    .rxIndicator (rxIndicator)
  );

endmodule
